// File: dzMicrocodePkg.sv
package dzMicrocodePkg;

	////////////////////
	// Sizes
	////////////////////
	localparam int dataWidth = 8;
	localparam int pcWidth = 16;
	localparam int flowIdxWidth = 6;
	localparam int queueDepth = 4;
	localparam int queuePtrWidth = $clog2(queueDepth);
	localparam int numRegs = 7;

	// Flow start rows in the microcode ROM
	localparam logic [flowIdxWidth-1:0] flowDefault = 6'd0;
	localparam logic [flowIdxWidth-1:0] flowNop = 6'd1;
	localparam logic [flowIdxWidth-1:0] flowLdRn = 6'd2;
	localparam logic [flowIdxWidth-1:0] flowIncR = 6'd4;
	localparam logic [flowIdxWidth-1:0] flowDecR = 6'd5;
	localparam logic [flowIdxWidth-1:0] flowAddR = 6'd6;
	localparam logic [flowIdxWidth-1:0] flowSubR = 6'd9;

	////////////////////
	// Micro-op fields
	////////////////////
	typedef enum logic [2:0] {
		op,
		inc,
		incEof,
		incEofFu,
		updateFlags
	} flowCtl_e;

	typedef enum logic [2:0] {
		nop,
		srm,
		inc8,
		dec8,
		sx16r,
		srx16,
		addx16,
		subx16
	} uopOp_e;

	typedef enum logic [2:0] {
		regA,
		regB,
		regC,
		regD,
		regE,
		regH,
		regL,
		regNull
	} regSel_e;

	typedef struct packed {
		flowCtl_e flowCtl;
		uopOp_e operation;
		regSel_e operand;
		logic [dataWidth-1:0] literal;
	} uop_s;

	// Kept opcodes, standard encodings
	typedef enum logic [7:0] {
		opNop = 8'h00,
		opLdBn = 8'h06, opLdCn = 8'h0E, opLdDn = 8'h16, opLdEn = 8'h1E,
		opLdHn = 8'h26, opLdLn = 8'h2E, opLdAn = 8'h3E,
		opIncB = 8'h04, opIncC = 8'h0C, opIncD = 8'h14, opIncE = 8'h1C,
		opIncH = 8'h24, opIncL = 8'h2C, opIncA = 8'h3C,
		opDecB = 8'h05, opDecC = 8'h0D, opDecD = 8'h15, opDecE = 8'h1D,
		opDecH = 8'h25, opDecL = 8'h2D, opDecA = 8'h3D,
		opAddB = 8'h80, opAddC = 8'h81, opAddD = 8'h82, opAddE = 8'h83,
		opAddH = 8'h84, opAddL = 8'h85, opAddA = 8'h87,
		opSubB = 8'h90, opSubC = 8'h91, opSubD = 8'h92, opSubE = 8'h93,
		opSubH = 8'h94, opSubL = 8'h95, opSubA = 8'h97
	} opcode_e;

	// Last micro-op of a flow
	function automatic logic isEndOfFlow(flowCtl_e ctl);
		return (ctl == incEof) || (ctl == incEofFu);
	endfunction

	// Micro-op moves the PC forward by one
	function automatic logic stepsPc(flowCtl_e ctl);
		return (ctl == inc) || (ctl == incEof) || (ctl == incEofFu);
	endfunction

endpackage

// File: uopLink.sv
`timescale 1ns/10ps

interface uopLink ();

	dzMicrocodePkg::uop_s uop;
	logic push;
	logic full;
	logic pop;
	logic empty;
	// Oldest micro-op held by the queue
	dzMicrocodePkg::uop_s head;

	modport writer (
		output uop,
		output push,
		input full
	);

	modport reader (
		output pop,
		input head,
		input empty
	);

	modport store (
		input uop,
		input push,
		input pop,
		output full,
		output empty,
		output head
	);

endinterface

// File: microcodeSequencer.sv
`timescale 1ns/10ps

module microcodeSequencer (
	input logic clk,
	input logic arstN,
	input logic issue,
	input logic [7:0] opcode,
	input logic [7:0] literal,
	output logic ready,
	uopLink.writer uopOut
);

	typedef enum logic {
		seqIdle,
		seqRun
	} seqState_e;

	seqState_e state;
	logic [dzMicrocodePkg::flowIdxWidth-1:0] flowAddr;
	logic [dzMicrocodePkg::flowIdxWidth-1:0] flowStart;
	logic [dzMicrocodePkg::dataWidth-1:0] literalHold;
	dzMicrocodePkg::regSel_e opReg;
	dzMicrocodePkg::regSel_e opRegHold;
	dzMicrocodePkg::flowCtl_e romCtl;
	dzMicrocodePkg::uopOp_e romOp;
	dzMicrocodePkg::regSel_e romReg;
	dzMicrocodePkg::regSel_e uopReg;

	// Register field of the opcode, (HL) has no register here
	function automatic dzMicrocodePkg::regSel_e gbReg(logic [2:0] code);
		case (code)
			3'd0: return dzMicrocodePkg::regB;
			3'd1: return dzMicrocodePkg::regC;
			3'd2: return dzMicrocodePkg::regD;
			3'd3: return dzMicrocodePkg::regE;
			3'd4: return dzMicrocodePkg::regH;
			3'd5: return dzMicrocodePkg::regL;
			3'd7: return dzMicrocodePkg::regA;
			default: return dzMicrocodePkg::regNull;
		endcase
	endfunction

	////////////////////
	// Opcode to flow
	////////////////////
	always_comb
	begin
		flowStart = dzMicrocodePkg::flowDefault;
		opReg = gbReg(opcode[5:3]);
		case (opcode)
			dzMicrocodePkg::opNop:
				flowStart = dzMicrocodePkg::flowNop;
			dzMicrocodePkg::opLdBn, dzMicrocodePkg::opLdCn, dzMicrocodePkg::opLdDn,
			dzMicrocodePkg::opLdEn, dzMicrocodePkg::opLdHn, dzMicrocodePkg::opLdLn,
			dzMicrocodePkg::opLdAn:
				flowStart = dzMicrocodePkg::flowLdRn;
			dzMicrocodePkg::opIncB, dzMicrocodePkg::opIncC, dzMicrocodePkg::opIncD,
			dzMicrocodePkg::opIncE, dzMicrocodePkg::opIncH, dzMicrocodePkg::opIncL,
			dzMicrocodePkg::opIncA:
				flowStart = dzMicrocodePkg::flowIncR;
			dzMicrocodePkg::opDecB, dzMicrocodePkg::opDecC, dzMicrocodePkg::opDecD,
			dzMicrocodePkg::opDecE, dzMicrocodePkg::opDecH, dzMicrocodePkg::opDecL,
			dzMicrocodePkg::opDecA:
				flowStart = dzMicrocodePkg::flowDecR;
			dzMicrocodePkg::opAddB, dzMicrocodePkg::opAddC, dzMicrocodePkg::opAddD,
			dzMicrocodePkg::opAddE, dzMicrocodePkg::opAddH, dzMicrocodePkg::opAddL,
			dzMicrocodePkg::opAddA:
			begin
				flowStart = dzMicrocodePkg::flowAddR;
				opReg = gbReg(opcode[2:0]);
			end
			dzMicrocodePkg::opSubB, dzMicrocodePkg::opSubC, dzMicrocodePkg::opSubD,
			dzMicrocodePkg::opSubE, dzMicrocodePkg::opSubH, dzMicrocodePkg::opSubL,
			dzMicrocodePkg::opSubA:
			begin
				flowStart = dzMicrocodePkg::flowSubR;
				opReg = gbReg(opcode[2:0]);
			end
			default: ;
		endcase
	end

	////////////////////
	// Microcode ROM
	////////////////////
	// Operand regNull stands for the register named by the opcode
	always_comb
	begin
		romCtl = dzMicrocodePkg::incEof;
		romOp = dzMicrocodePkg::nop;
		romReg = dzMicrocodePkg::regNull;
		case (flowAddr)
			dzMicrocodePkg::flowLdRn:
				romCtl = dzMicrocodePkg::inc;
			dzMicrocodePkg::flowLdRn + 1:
				romOp = dzMicrocodePkg::srm;
			dzMicrocodePkg::flowIncR:
			begin
				romCtl = dzMicrocodePkg::incEofFu;
				romOp = dzMicrocodePkg::inc8;
			end
			dzMicrocodePkg::flowDecR:
			begin
				romCtl = dzMicrocodePkg::incEofFu;
				romOp = dzMicrocodePkg::dec8;
			end
			dzMicrocodePkg::flowAddR, dzMicrocodePkg::flowSubR:
			begin
				romCtl = dzMicrocodePkg::op;
				romOp = dzMicrocodePkg::sx16r;
				romReg = dzMicrocodePkg::regA;
			end
			dzMicrocodePkg::flowAddR + 1:
			begin
				romCtl = dzMicrocodePkg::updateFlags;
				romOp = dzMicrocodePkg::addx16;
			end
			dzMicrocodePkg::flowSubR + 1:
			begin
				romCtl = dzMicrocodePkg::updateFlags;
				romOp = dzMicrocodePkg::subx16;
			end
			dzMicrocodePkg::flowAddR + 2, dzMicrocodePkg::flowSubR + 2:
			begin
				romOp = dzMicrocodePkg::srx16;
				romReg = dzMicrocodePkg::regA;
			end
			// Default and NOP rows advance the PC only
			default: ;
		endcase
	end

	assign uopReg = (romReg == dzMicrocodePkg::regNull && romOp != dzMicrocodePkg::nop) ?
		opRegHold : romReg;
	assign uopOut.uop = '{romCtl, romOp, uopReg, literalHold};
	assign uopOut.push = (state == seqRun) && !uopOut.full;
	assign ready = (state == seqIdle);

	// Flow walker
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= seqIdle;
			flowAddr <= '0;
		end
		else if (state == seqIdle)
		begin
			if (issue)
			begin
				state <= seqRun;
				flowAddr <= flowStart;
			end
		end
		else if (uopOut.push)
		begin
			if (dzMicrocodePkg::isEndOfFlow(romCtl))
				state <= seqIdle;
			else
				flowAddr <= flowAddr + 1'b1;
		end
	end

	// Instruction payload captured at issue
	always_ff @(posedge clk)
	begin
		if (issue && ready)
		begin
			literalHold <= literal;
			opRegHold <= opReg;
		end
	end

endmodule

// File: uopQueue.sv
`timescale 1ns/10ps

module uopQueue (
	input logic clk,
	input logic arstN,
	uopLink.store inSide,
	uopLink.store outSide
);

	dzMicrocodePkg::uop_s entries [dzMicrocodePkg::queueDepth];
	logic [dzMicrocodePkg::queuePtrWidth-1:0] wrPtr;
	logic [dzMicrocodePkg::queuePtrWidth-1:0] rdPtr;
	logic [dzMicrocodePkg::queuePtrWidth:0] count;
	logic full;
	logic empty;
	logic doPush;
	logic doPop;

	assign full = (count == dzMicrocodePkg::queueDepth);
	assign empty = (count == '0);
	assign doPop = outSide.pop && !empty;
	// A pop frees the head slot in the same cycle
	assign doPush = inSide.push && (!full || doPop);

	// Both sides see the same levels and head
	assign inSide.full = full;
	assign outSide.full = full;
	assign inSide.empty = empty;
	assign outSide.empty = empty;
	assign inSide.head = entries[rdPtr];
	assign outSide.head = entries[rdPtr];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			entries[wrPtr] <= inSide.uop;
	end

endmodule

// File: uopExecutor.sv
`timescale 1ns/10ps

module uopExecutor (
	input logic clk,
	input logic arstN,
	uopLink.reader uopIn,
	input dzMicrocodePkg::regSel_e readSel,
	output logic [7:0] readData,
	output logic zeroFlag,
	output logic carryFlag,
	output logic [15:0] pc,
	output logic retire
);

	dzMicrocodePkg::uop_s cur;
	logic [dzMicrocodePkg::dataWidth-1:0] regFile [dzMicrocodePkg::numRegs];
	logic [dzMicrocodePkg::dataWidth-1:0] srcReg;
	logic [dzMicrocodePkg::dataWidth-1:0] byteResult;
	logic [dzMicrocodePkg::dataWidth-1:0] regWriteData;
	logic [dzMicrocodePkg::pcWidth-1:0] scratch;
	logic [dzMicrocodePkg::pcWidth-1:0] srcWide;
	logic [dzMicrocodePkg::pcWidth-1:0] scratchResult;
	logic regWrite;
	logic doPop;

	// One micro-op per cycle whenever one is waiting
	assign doPop = !uopIn.empty;
	assign uopIn.pop = doPop;
	assign cur = uopIn.head;

	////////////////////
	// Operand read
	////////////////////
	always_comb
	begin
		readData = '0;
		if (readSel != dzMicrocodePkg::regNull)
			readData = regFile[readSel];
		srcReg = '0;
		if (cur.operand != dzMicrocodePkg::regNull)
			srcReg = regFile[cur.operand];
		srcWide = '0;
		srcWide[dzMicrocodePkg::dataWidth-1:0] = srcReg;
	end

	////////////////////
	// Datapath
	////////////////////
	always_comb
	begin
		byteResult = (cur.operation == dzMicrocodePkg::dec8) ? srcReg - 1'b1 : srcReg + 1'b1;
		// Bit 8 is the carry for add, the borrow for subtract
		scratchResult = (cur.operation == dzMicrocodePkg::subx16) ?
			scratch - srcWide : scratch + srcWide;
		regWrite = 1'b0;
		regWriteData = cur.literal;
		case (cur.operation)
			dzMicrocodePkg::srm:
				regWrite = 1'b1;
			dzMicrocodePkg::inc8, dzMicrocodePkg::dec8:
			begin
				regWrite = 1'b1;
				regWriteData = byteResult;
			end
			dzMicrocodePkg::srx16:
			begin
				regWrite = 1'b1;
				regWriteData = scratch[dzMicrocodePkg::dataWidth-1:0];
			end
			default: ;
		endcase
		if (!doPop || cur.operand == dzMicrocodePkg::regNull)
			regWrite = 1'b0;
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			for (int i = 0; i < dzMicrocodePkg::numRegs; i++)
				regFile[i] <= '0;
			scratch <= '0;
			zeroFlag <= 1'b0;
			carryFlag <= 1'b0;
			pc <= '0;
			retire <= 1'b0;
		end
		else
		begin
			retire <= doPop && dzMicrocodePkg::isEndOfFlow(cur.flowCtl);
			if (regWrite)
				regFile[cur.operand] <= regWriteData;
			if (doPop)
			begin
				if (dzMicrocodePkg::stepsPc(cur.flowCtl))
					pc <= pc + 1'b1;
				if (cur.operation == dzMicrocodePkg::sx16r)
					scratch <= srcWide;
				else if (cur.operation == dzMicrocodePkg::addx16 ||
					cur.operation == dzMicrocodePkg::subx16)
					scratch <= scratchResult;
				// INC and DEC touch only the zero flag
				if (cur.flowCtl == dzMicrocodePkg::incEofFu)
					zeroFlag <= (byteResult == '0);
				if (cur.flowCtl == dzMicrocodePkg::updateFlags)
				begin
					zeroFlag <= (scratchResult[dzMicrocodePkg::dataWidth-1:0] == '0);
					carryFlag <= scratchResult[dzMicrocodePkg::dataWidth];
				end
			end
		end
	end

endmodule

// File: dzMicrocodeCore.sv
`timescale 1ns/10ps

module dzMicrocodeCore (
	input logic clk,
	input logic arstN,
	input logic issue,
	input logic [7:0] opcode,
	input logic [7:0] literal,
	output logic ready,
	output logic retire,
	input dzMicrocodePkg::regSel_e readSel,
	output logic [7:0] readData,
	output logic zeroFlag,
	output logic carryFlag,
	output logic [15:0] pc
);

	uopLink seqToQueue ();
	uopLink queueToExec ();

	// Unused directions of each link
	assign seqToQueue.pop = 1'b0;
	assign queueToExec.push = 1'b0;
	assign queueToExec.uop = '0;

	microcodeSequencer sequencer (
		.clk(clk),
		.arstN(arstN),
		.issue(issue),
		.opcode(opcode),
		.literal(literal),
		.ready(ready),
		.uopOut(seqToQueue.writer)
	);

	uopQueue queue (
		.clk(clk),
		.arstN(arstN),
		.inSide(seqToQueue.store),
		.outSide(queueToExec.store)
	);

	uopExecutor executor (
		.clk(clk),
		.arstN(arstN),
		.uopIn(queueToExec.reader),
		.readSel(readSel),
		.readData(readData),
		.zeroFlag(zeroFlag),
		.carryFlag(carryFlag),
		.pc(pc),
		.retire(retire)
	);

endmodule

// File: tbDzMicrocodeCore.sv
`timescale 1ns/10ps

module tbDzMicrocodeCore;

	typedef struct packed {
		logic [2:0] dest;
		logic [7:0] value;
		logic zero;
		logic carry;
		logic [15:0] pc;
	} expect_s;

	logic clk = 1'b0;
	logic arstN;
	logic issue;
	logic [7:0] opcode;
	logic [7:0] literal;
	logic ready;
	logic retire;
	dzMicrocodePkg::regSel_e readSel;
	logic [7:0] readData;
	logic zeroFlag;
	logic carryFlag;
	logic [15:0] pc;

	// Stimulus table with one entry per instruction
	logic [7:0] rowOp [$];
	logic [7:0] rowLit [$];
	int rowGap [$];
	logic rowRand [$];
	int rowPcStep [$];
	int rowTest [$];
	string testNames [6] = '{"reset", "load", "add and subtract",
		"increment and decrement", "back to back", "unknown opcode"};

	// Model registers in regSel order
	// Index 7 stands for regNull and stays zero
	logic [7:0] modelRegs [8];
	logic modelZero;
	logic modelCarry;
	logic [15:0] modelPc;
	expect_s pending [$];
	expect_s retired;

	int issueCount = 0;
	int retireCount = 0;
	int checks = 0;
	int errors = 0;
	int testErrors = 0;
	int failedTests = 0;
	int cycles = 0;
	int limit = 0;
	logic [31:0] randWord;

	dzMicrocodeCore i_dut (
		.clk(clk),
		.arstN(arstN),
		.issue(issue),
		.opcode(opcode),
		.literal(literal),
		.ready(ready),
		.retire(retire),
		.readSel(readSel),
		.readData(readData),
		.zeroFlag(zeroFlag),
		.carryFlag(carryFlag),
		.pc(pc)
	);

	always #5 clk = ~clk;

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected)
		begin
			errors++;
			testErrors++;
			$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
		end
	endtask

	task automatic addRow(input logic [7:0] op, input logic [7:0] lit, input int gap,
		input logic useRand, input int pcStep, input int testId);
		rowOp.push_back(op);
		rowLit.push_back(lit);
		rowGap.push_back(gap);
		rowRand.push_back(useRand);
		rowPcStep.push_back(pcStep);
		rowTest.push_back(testId);
	endtask

	// Opcode register field 7 is A and 0 to 5 are B to L
	function automatic int fieldToIdx(logic [2:0] code);
		return (code == 3'd7) ? 0 : int'(code) + 1;
	endfunction

	////////////////////
	// Reference model
	////////////////////
	task automatic applyModel(input logic [7:0] op, input logic [7:0] lit, input int pcStep);
		int dest;
		logic [7:0] src;
		logic [8:0] wide;
		expect_s e;
		dest = 7;
		if (op[7:6] == 2'b00 && op[2:0] == 3'b110 && op[5:3] != 3'b110)
		begin
			dest = fieldToIdx(op[5:3]);
			modelRegs[dest] = lit;
		end
		else if (op[7:6] == 2'b00 && op[2:1] == 2'b10 && op[5:3] != 3'b110)
		begin
			// Bit 0 picks DEC over INC and the carry stays
			dest = fieldToIdx(op[5:3]);
			modelRegs[dest] = op[0] ? modelRegs[dest] - 8'd1 : modelRegs[dest] + 8'd1;
			modelZero = (modelRegs[dest] == 8'h00);
		end
		else if ((op[7:3] == 5'b10000 || op[7:3] == 5'b10010) && op[2:0] != 3'b110)
		begin
			src = modelRegs[fieldToIdx(op[2:0])];
			wide = op[4] ? {1'b0, modelRegs[0]} - {1'b0, src} : {1'b0, modelRegs[0]} + {1'b0, src};
			dest = 0;
			modelRegs[0] = wide[7:0];
			modelZero = (wide[7:0] == 8'h00);
			modelCarry = wide[8];
		end
		modelPc = modelPc + 16'(pcStep);
		e.dest = 3'(dest);
		e.value = modelRegs[dest];
		e.zero = modelZero;
		e.carry = modelCarry;
		e.pc = modelPc;
		pending.push_back(e);
		issueCount++;
	endtask

	task automatic buildTable();
		// Loads with random literals
		addRow(8'h06, 8'h00, 2, 1'b1, 2, 1);
		addRow(8'h0E, 8'h00, 1, 1'b1, 2, 1);
		addRow(8'h16, 8'h00, 1, 1'b1, 2, 1);
		addRow(8'h1E, 8'h00, 1, 1'b1, 2, 1);
		addRow(8'h26, 8'h00, 1, 1'b1, 2, 1);
		addRow(8'h2E, 8'h00, 1, 1'b1, 2, 1);
		addRow(8'h3E, 8'h00, 1, 1'b1, 2, 1);
		// F0h + 20h carries out before the zero and borrow cases
		addRow(8'h3E, 8'hF0, 2, 1'b0, 2, 2);
		addRow(8'h06, 8'h20, 1, 1'b0, 2, 2);
		addRow(8'h80, 8'h00, 1, 1'b0, 1, 2);
		addRow(8'h0E, 8'h10, 1, 1'b0, 2, 2);
		addRow(8'h91, 8'h00, 1, 1'b0, 1, 2);
		addRow(8'h90, 8'h00, 1, 1'b0, 1, 2);
		addRow(8'h82, 8'h00, 1, 1'b0, 1, 2);
		addRow(8'h93, 8'h00, 1, 1'b0, 1, 2);
		addRow(8'h84, 8'h00, 1, 1'b0, 1, 2);
		addRow(8'h95, 8'h00, 1, 1'b0, 1, 2);
		addRow(8'h81, 8'h00, 1, 1'b0, 1, 2);
		addRow(8'h97, 8'h00, 1, 1'b0, 1, 2);
		addRow(8'h87, 8'h00, 1, 1'b0, 1, 2);
		addRow(8'h3E, 8'h05, 1, 1'b0, 2, 2);
		addRow(8'h90, 8'h00, 1, 1'b0, 1, 2);
		// Wrap cases on B and C first
		// Carry stays set from the last SUB
		addRow(8'h06, 8'hFF, 2, 1'b0, 2, 3);
		addRow(8'h04, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h05, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h0E, 8'h01, 1, 1'b0, 2, 3);
		addRow(8'h0D, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h0C, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h3C, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h3D, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h14, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h15, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h1C, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h1D, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h24, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h25, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h2C, 8'h00, 1, 1'b0, 1, 3);
		addRow(8'h2D, 8'h00, 1, 1'b0, 1, 3);
		// No idle cycles between issues
		addRow(8'h80, 8'h00, 2, 1'b0, 1, 4);
		addRow(8'h0C, 8'h00, 0, 1'b0, 1, 4);
		addRow(8'h16, 8'h00, 0, 1'b1, 2, 4);
		addRow(8'h92, 8'h00, 0, 1'b0, 1, 4);
		addRow(8'h00, 8'h00, 0, 1'b0, 1, 4);
		addRow(8'h1D, 8'h00, 0, 1'b0, 1, 4);
		addRow(8'h26, 8'h00, 0, 1'b1, 2, 4);
		addRow(8'h84, 8'h00, 0, 1'b0, 1, 4);
		// Opcodes outside the kept set
		addRow(8'hC3, 8'h5A, 2, 1'b0, 1, 5);
		addRow(8'h76, 8'hA5, 2, 1'b0, 1, 5);
	endtask

	task automatic issueRow(input int i);
		logic [7:0] lit;
		repeat (rowGap[i])
		begin
			@(posedge clk);
			#1;
		end
		while (!ready)
		begin
			@(posedge clk);
			#1;
		end
		lit = rowLit[i];
		if (rowRand[i])
		begin
			randWord = $urandom;
			lit = randWord[7:0];
		end
		issue = 1'b1;
		opcode = rowOp[i];
		literal = lit;
		applyModel(rowOp[i], lit, rowPcStep[i]);
		@(posedge clk);
		#1;
		issue = 1'b0;
	endtask

	// Reads every readSel value over eight cycles
	task automatic checkAllRegs();
		for (int r = 0; r < 8; r++)
		begin
			@(posedge clk);
			#1;
			readSel = dzMicrocodePkg::regSel_e'(r[2:0]);
			#4;
			checkValue($sformatf("readData[%0d]", r), readData, modelRegs[r]);
		end
		checkValue("zeroFlag", zeroFlag, modelZero);
		checkValue("carryFlag", carryFlag, modelCarry);
		checkValue("pc", pc, modelPc);
	endtask

	task automatic reportTest(input int t);
		if (testErrors != 0)
			failedTests++;
		$display("Test %0d (%s): %0d mismatches", t, testNames[t], testErrors);
		testErrors = 0;
	endtask

	// Retire monitor comparing in issue order
	always @(posedge clk)
	begin
		#2;
		if (arstN && retire)
		begin
			retireCount++;
			if (pending.size() == 0)
			begin
				errors++;
				testErrors++;
				$display("A retire pulse came with no instruction outstanding");
			end
			else
			begin
				retired = pending.pop_front();
				if (retired.dest != 3'd7)
				begin
					readSel = dzMicrocodePkg::regSel_e'(retired.dest);
					#1;
					checkValue("readData", readData, retired.value);
				end
				checkValue("zeroFlag", zeroFlag, retired.zero);
				checkValue("carryFlag", carryFlag, retired.carry);
				checkValue("pc", pc, retired.pc);
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (limit != 0 && cycles >= limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", limit);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////
	// Main sequence
	////////////////////
	initial
	begin
		randWord = $urandom(57703);
		arstN = 1'b0;
		issue = 1'b0;
		opcode = 8'h00;
		literal = 8'h00;
		readSel = dzMicrocodePkg::regA;
		for (int r = 0; r < 8; r++)
			modelRegs[r] = 8'h00;
		modelZero = 1'b0;
		modelCarry = 1'b0;
		modelPc = 16'h0000;
		buildTable();
		limit = 5 + 8 * rowOp.size() + 16 * 6;
		foreach (rowGap[i])
			limit += rowGap[i];
		repeat (5) @(posedge clk);
		#1;
		arstN = 1'b1;

		checkValue("ready", ready, 1'b1);
		checkValue("retire", retire, 1'b0);
		checkAllRegs();
		reportTest(0);

		for (int t = 1; t < 6; t++)
		begin
			foreach (rowOp[i])
			begin
				if (rowTest[i] == t)
					issueRow(i);
			end
			// Drain until every issued instruction has retired
			while (pending.size() != 0 || !ready)
			begin
				@(posedge clk);
				#1;
			end
			checkAllRegs();
			checkValue("retireCount", retireCount, issueCount);
			reportTest(t);
		end

		$display("Summary: 6 tests, %0d with mismatches, %0d checks, %0d errors",
			failedTests, checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: vlog.f
dzMicrocodePkg.sv
uopLink.sv
microcodeSequencer.sv
uopQueue.sv
uopExecutor.sv
dzMicrocodeCore.sv
tbDzMicrocodeCore.sv

// File: Bender.yml
package:
  name: dzMicrocodeCore

sources:
  - dzMicrocodePkg.sv
  - uopLink.sv
  - microcodeSequencer.sv
  - uopQueue.sv
  - uopExecutor.sv
  - dzMicrocodeCore.sv
  - target: simulation
    files:
      - tbDzMicrocodeCore.sv
